// File: include/heap_params.svh
`ifndef HEAP_PARAMS_SVH
`define HEAP_PARAMS_SVH

// address and size width
`define HEAP_DATA_W 16

// total heap span in bytes
`define HEAP_BYTES 512

// every block starts with a header of this size
`define HEAP_HDR_BYTES 8

// header store address step, one slot per granule
`define HEAP_GRANULE 8

// remainders below this are handed out with the block
`define HEAP_MIN_SPLIT 16

`endif

// File: verilog/heap_pkg.sv
`include "heap_params.svh"

package heap_pkg;

  typedef logic [`HEAP_DATA_W-1:0] addr_t;
  typedef logic [`HEAP_DATA_W-1:0] size_t;

  // a zero next ends the list
  typedef struct packed {
    size_t size;
    addr_t next;
  } header_t;

  typedef enum logic {
    first_fit,
    best_fit
  } alloc_strategy_e;

  typedef struct packed {
    logic            is_alloc;
    alloc_strategy_e strategy;
    size_t           size;
    addr_t           addr;  // payload address of a free
  } heap_req_t;

  typedef struct packed {
    logic  is_alloc;
    logic  ok;
    addr_t data;
  } heap_rsp_t;

  typedef struct packed {
    logic    found;
    addr_t   target_addr;
    header_t target_hdr;
    addr_t   prev_addr;
  } walk_result_t;

  // a write with size zero only updates next
  typedef struct packed {
    logic    valid;
    addr_t   addr;
    header_t hdr;
  } mem_wr_t;

  typedef enum logic [1:0] {walk_idle, walk_issue, walk_compare} walker_state_e;
  typedef enum logic [1:0] {upd_idle, upd_write} update_state_e;
  typedef enum logic [1:0] {ctrl_idle, ctrl_walk, ctrl_update, ctrl_respond} ctrl_state_e;

endpackage

// File: verilog/heap_header_mem.sv
`timescale 1ns/1ps
`include "heap_params.svh"

module heap_header_mem (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              rd_en_i,
  input  heap_pkg::addr_t   rd_addr_i,
  output heap_pkg::header_t rd_hdr_o,
  input  heap_pkg::mem_wr_t wr_i
);
  import heap_pkg::*;

  localparam int unsigned num_slots = `HEAP_BYTES / `HEAP_GRANULE;
  localparam int unsigned idx_w     = $clog2(num_slots);
  localparam int unsigned gran_sh   = $clog2(`HEAP_GRANULE);
  localparam int unsigned first_idx = `HEAP_HDR_BYTES / `HEAP_GRANULE;

  // sentinel at 0 points at the single free block right behind it
  localparam header_t init_sentinel = '{
    size: '0,
    next: addr_t'(`HEAP_HDR_BYTES)
  };
  localparam header_t init_block = '{
    size: size_t'(`HEAP_BYTES - 2 * `HEAP_HDR_BYTES),
    next: '0
  };

  header_t mem_q [num_slots];

  logic [idx_w-1:0] rd_idx;
  logic [idx_w-1:0] wr_idx;

  assign rd_idx = rd_addr_i[gran_sh +: idx_w];
  assign wr_idx = wr_i.addr[gran_sh +: idx_w];

  // ####################
  // storage
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int i = 0; i < num_slots; i++) begin
        mem_q[i] <= '0;
      end
      mem_q[0]         <= init_sentinel;
      mem_q[first_idx] <= init_block;
    end else if (wr_i.valid) begin
      if (wr_i.hdr.size != '0) begin
        mem_q[wr_idx].size <= wr_i.hdr.size;
      end
      mem_q[wr_idx].next <= wr_i.hdr.next;  // link is always written
    end
  end

  // registered read, one cycle latency
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      rd_hdr_o <= mem_q[rd_idx];
    end
  end

endmodule

// File: verilog/heap_list_walker.sv
`timescale 1ns/1ps

module heap_list_walker (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   start_i,
  input  heap_pkg::heap_req_t    req_i,
  output logic                   done_o,
  output heap_pkg::walk_result_t result_o,
  output logic                   rd_en_o,
  output heap_pkg::addr_t        rd_addr_o,
  input  heap_pkg::header_t      rd_hdr_i
);
  import heap_pkg::*;

  walker_state_e state_d, state_q;
  heap_req_t     req_d, req_q;
  addr_t         curr_d, curr_q;
  addr_t         prev_d, prev_q;
  walk_result_t  cand_d, cand_q;
  size_t         best_diff_d, best_diff_q;
  logic          done_d, done_q;

  logic         fits;
  logic         last;
  logic         finish;
  size_t        diff;
  walk_result_t visit;

  // the sentinel never satisfies an allocation
  assign fits  = (curr_q != '0) && (rd_hdr_i.size >= req_q.size);
  assign diff  = rd_hdr_i.size - req_q.size;
  assign last  = (rd_hdr_i.next == '0);
  assign visit = '{found: 1'b1, target_addr: curr_q, target_hdr: rd_hdr_i, prev_addr: prev_q};

  always_comb begin
    state_d     = state_q;
    req_d       = req_q;
    curr_d      = curr_q;
    prev_d      = prev_q;
    cand_d      = cand_q;
    best_diff_d = best_diff_q;
    done_d      = 1'b0;
    finish      = 1'b0;

    unique case (state_q)
      walk_idle: begin
        if (start_i) begin
          req_d       = req_i;
          curr_d      = '0;  // start at the sentinel
          prev_d      = '0;
          cand_d      = '0;
          best_diff_d = '1;
          state_d     = walk_issue;
        end
      end
      walk_issue: state_d = walk_compare;
      walk_compare: begin
        if (!req_q.is_alloc) begin
          // stop at the last header below the freed one
          if (last || (rd_hdr_i.next > req_q.addr)) begin
            cand_d = visit;
            finish = 1'b1;
          end
        end else if (req_q.strategy == first_fit) begin
          if (fits) begin
            cand_d = visit;
            finish = 1'b1;
          end else if (last) begin
            finish = 1'b1;  // no fit, found stays clear
          end
        end else begin
          if (fits && (diff < best_diff_q)) begin  // strict, so the earliest wins a tie
            cand_d      = visit;
            best_diff_d = diff;
          end
          finish = last;
        end

        if (finish) begin
          done_d  = 1'b1;
          state_d = walk_idle;
        end else begin
          prev_d  = curr_q;
          curr_d  = rd_hdr_i.next;
          state_d = walk_issue;
        end
      end
      default: state_d = walk_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= walk_idle;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= done_d;
    end
  end

  always_ff @(posedge clk_i) begin
    req_q       <= req_d;
    curr_q      <= curr_d;
    prev_q      <= prev_d;
    cand_q      <= cand_d;
    best_diff_q <= best_diff_d;
  end

  assign rd_en_o   = (state_q == walk_issue);
  assign rd_addr_o = curr_q;
  assign done_o    = done_q;
  assign result_o  = cand_q;  // held until the next start

endmodule

// File: verilog/heap_list_update.sv
`timescale 1ns/1ps
`include "heap_params.svh"

module heap_list_update (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   start_i,
  input  heap_pkg::heap_req_t    req_i,
  input  heap_pkg::walk_result_t walk_i,
  output logic                   done_o,
  output heap_pkg::mem_wr_t      wr_o
);
  import heap_pkg::*;

  update_state_e state_q;
  mem_wr_t       slot_q [3];
  logic          done_q;

  size_t   rem;
  addr_t   new_addr;
  logic    split;
  mem_wr_t plan_wr [3];

  assign rem      = walk_i.target_hdr.size - req_i.size;
  assign new_addr = walk_i.target_addr + addr_t'(`HEAP_HDR_BYTES) + req_i.size;
  assign split    = (rem >= size_t'(`HEAP_MIN_SPLIT));

  // ####################
  // header writes per case, packed from slot 0
  always_comb begin
    plan_wr = '{default: '0};
    if (walk_i.found) begin
      if (req_i.is_alloc && split) begin
        plan_wr[0] = '{valid: 1'b1, addr: walk_i.target_addr,
                       hdr: '{size: req_i.size, next: '0}};
        plan_wr[1] = '{valid: 1'b1, addr: new_addr,
                       hdr: '{size: rem - size_t'(`HEAP_HDR_BYTES),
                              next: walk_i.target_hdr.next}};
        plan_wr[2] = '{valid: 1'b1, addr: walk_i.prev_addr,
                       hdr: '{size: '0, next: new_addr}};  // relink only
      end else if (req_i.is_alloc) begin
        // whole block goes out
        plan_wr[0] = '{valid: 1'b1, addr: walk_i.target_addr,
                       hdr: '{size: walk_i.target_hdr.size, next: '0}};
        plan_wr[1] = '{valid: 1'b1, addr: walk_i.prev_addr,
                       hdr: '{size: '0, next: walk_i.target_hdr.next}};
      end else begin
        // freed header keeps its size, target links to it
        plan_wr[0] = '{valid: 1'b1, addr: req_i.addr,
                       hdr: '{size: '0, next: walk_i.target_hdr.next}};
        plan_wr[1] = '{valid: 1'b1, addr: walk_i.target_addr,
                       hdr: '{size: walk_i.target_hdr.size, next: req_i.addr}};
      end
    end
  end

  // ####################
  // one write per cycle out of slot 0
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= upd_idle;
      slot_q  <= '{default: '0};
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      unique case (state_q)
        upd_idle: begin
          if (start_i) begin
            slot_q <= plan_wr;
            if (plan_wr[0].valid) begin
              state_q <= upd_write;
            end else begin
              done_q <= 1'b1;  // nothing to write
            end
          end
        end
        upd_write: begin
          slot_q[0] <= slot_q[1];
          slot_q[1] <= slot_q[2];
          slot_q[2] <= '0;
          if (!slot_q[1].valid) begin
            done_q  <= 1'b1;
            state_q <= upd_idle;
          end
        end
        default: state_q <= upd_idle;
      endcase
    end
  end

  assign wr_o   = slot_q[0];
  assign done_o = done_q;

endmodule

// File: verilog/heap_alloc_ctrl.sv
`timescale 1ns/1ps
`include "heap_params.svh"

module heap_alloc_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   req_valid_i,
  input  heap_pkg::heap_req_t    req_i,
  output logic                   req_ready_o,
  output logic                   rsp_valid_o,
  output heap_pkg::heap_rsp_t    rsp_o,
  input  logic                   rsp_ready_i,
  output logic                   walk_start_o,
  output heap_pkg::heap_req_t    walk_req_o,
  input  logic                   walk_done_i,
  input  heap_pkg::walk_result_t walk_result_i,
  output logic                   upd_start_o,
  input  logic                   upd_done_i
);
  import heap_pkg::*;

  ctrl_state_e  state_q;
  heap_req_t    req_q;
  walk_result_t res_q;
  logic         walk_start_q;
  logic         upd_start_q;

  heap_req_t req_conv;
  logic      accept;

  // a free walks with its header address
  always_comb begin
    req_conv = req_i;
    if (!req_i.is_alloc) begin
      req_conv.addr = req_i.addr - addr_t'(`HEAP_HDR_BYTES);
    end
  end

  assign accept = req_valid_i && req_ready_o;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q      <= ctrl_idle;
      walk_start_q <= 1'b0;
      upd_start_q  <= 1'b0;
    end else begin
      walk_start_q <= 1'b0;
      upd_start_q  <= 1'b0;
      unique case (state_q)
        ctrl_idle: begin
          if (accept) begin
            walk_start_q <= 1'b1;
            state_q      <= ctrl_walk;
          end
        end
        ctrl_walk: begin
          if (walk_done_i) begin
            if (req_q.is_alloc && !walk_result_i.found) begin
              state_q <= ctrl_respond;  // no fit, list untouched
            end else begin
              upd_start_q <= 1'b1;
              state_q     <= ctrl_update;
            end
          end
        end
        ctrl_update: if (upd_done_i) state_q <= ctrl_respond;
        ctrl_respond: if (rsp_ready_i) state_q <= ctrl_idle;
        default: state_q <= ctrl_idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= req_conv;
    end
    if ((state_q == ctrl_walk) && walk_done_i) begin
      res_q <= walk_result_i;
    end
  end

  assign req_ready_o  = (state_q == ctrl_idle);
  assign rsp_valid_o  = (state_q == ctrl_respond);
  assign walk_start_o = walk_start_q;
  assign upd_start_o  = upd_start_q;
  assign walk_req_o   = req_q;

  // built from latched state only, so it holds under back-pressure
  assign rsp_o = '{
    is_alloc: req_q.is_alloc,
    ok:       res_q.found,
    data:     (req_q.is_alloc && res_q.found) ?
              res_q.target_addr + addr_t'(`HEAP_HDR_BYTES) : '0
  };

endmodule

// File: verilog/heap_alloc_top.sv
`timescale 1ns/1ps

module heap_alloc_top (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                req_valid_i,
  input  heap_pkg::heap_req_t req_i,
  output logic                req_ready_o,
  output logic                rsp_valid_o,
  output heap_pkg::heap_rsp_t rsp_o,
  input  logic                rsp_ready_i
);
  import heap_pkg::*;

  logic         walk_start;
  heap_req_t    walk_req;
  logic         walk_done;
  walk_result_t walk_result;
  logic         upd_start;
  logic         upd_done;

  // header store ports
  logic    rd_en;
  addr_t   rd_addr;
  header_t rd_hdr;
  mem_wr_t mem_wr;

  heap_alloc_ctrl i_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_valid_i   (req_valid_i),
    .req_i         (req_i),
    .req_ready_o   (req_ready_o),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_o         (rsp_o),
    .rsp_ready_i   (rsp_ready_i),
    .walk_start_o  (walk_start),
    .walk_req_o    (walk_req),
    .walk_done_i   (walk_done),
    .walk_result_i (walk_result),
    .upd_start_o   (upd_start),
    .upd_done_i    (upd_done)
  );

  heap_list_walker i_walker (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .start_i   (walk_start),
    .req_i     (walk_req),
    .done_o    (walk_done),
    .result_o  (walk_result),
    .rd_en_o   (rd_en),
    .rd_addr_o (rd_addr),
    .rd_hdr_i  (rd_hdr)
  );

  heap_list_update i_update (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .start_i (upd_start),
    .req_i   (walk_req),  // free address already converted
    .walk_i  (walk_result),
    .done_o  (upd_done),
    .wr_o    (mem_wr)
  );

  heap_header_mem i_mem (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .rd_en_i   (rd_en),
    .rd_addr_i (rd_addr),
    .rd_hdr_o  (rd_hdr),
    .wr_i      (mem_wr)
  );

endmodule

// File: test/heap_alloc_assertions.sv
`timescale 1ns/1ps

module heap_alloc_assertions (
  input logic                clk_i,
  input logic                rst_ni,
  input logic                req_valid_i,
  input logic                req_ready_o,
  input logic                rsp_valid_o,
  input heap_pkg::heap_rsp_t rsp_o,
  input logic                rsp_ready_i
);

  int unsigned fail_count = 0;

  // ####################
  // request side
  no_accept_during_rsp: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(req_valid_i && req_ready_o && rsp_valid_o))
    else begin
      $error("request accepted while a response is pending");
      fail_count++;
    end

  busy_after_accept: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_valid_i && req_ready_o) |=> !req_ready_o)
    else begin
      $error("req_ready_o high while the core is busy");
      fail_count++;
    end

  // response side, held until ready
  rsp_held_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (rsp_valid_o && !rsp_ready_i) |=> (rsp_valid_o && $stable(rsp_o)))
    else begin
      $error("response changed under back-pressure");
      fail_count++;
    end

endmodule

bind heap_alloc_top heap_alloc_assertions i_assertions (.*);

// File: test/heap_alloc_tb.sv
`timescale 1ns/1ps

module heap_alloc_tb;
  import heap_pkg::*;

  localparam int num_patterns  = 18;
  localparam int pattern_words = 5;
  localparam int timeout_limit = num_patterns * 400;

  logic      clk;
  logic      rst_n;
  logic      req_valid;
  heap_req_t req;
  logic      req_ready;
  logic      rsp_valid;
  heap_rsp_t rsp;
  logic      rsp_ready;

  logic [15:0] pattern_mem [num_patterns * pattern_words];
  logic [31:0] rng_state;
  int          cycle_count;
  int          err_count;
  int          failed_tests;

  heap_alloc_top i_dut (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .req_valid_i (req_valid),
    .req_i       (req),
    .req_ready_o (req_ready),
    .rsp_valid_o (rsp_valid),
    .rsp_o       (rsp),
    .rsp_ready_i (rsp_ready)
  );

  always #50 clk = ~clk;

  // ####################
  // run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_limit) begin
      $display("timeout: the DUT did not finish within %0d cycles", timeout_limit);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_rsp(input heap_rsp_t got, input heap_rsp_t exp, input string msg);
    if (got !== exp) begin
      $display("FAILED at %0t: %s, got %h expected %h", $time, msg, got, exp);
      err_count++;
    end
  endtask

  task automatic check_ready(input logic got, input logic exp, input string msg);
    if (got !== exp) begin
      $display("FAILED at %0t: %s, got %b expected %b", $time, msg, got, exp);
      err_count++;
    end
  endtask

  // ####################
  // one request and its response
  task automatic run_pattern(input int idx);
    heap_req_t   next_req;
    heap_rsp_t   exp_rsp;
    logic [15:0] value;
    int          hold;
    int          errs_before;

    errs_before       = err_count;
    value             = pattern_mem[idx * pattern_words + 2];
    next_req          = '0;
    next_req.is_alloc = pattern_mem[idx * pattern_words][0];
    next_req.strategy = alloc_strategy_e'(pattern_mem[idx * pattern_words + 1][0]);
    if (next_req.is_alloc) begin
      next_req.size = value;
    end else begin
      next_req.addr = value;  // payload address
    end
    exp_rsp.is_alloc = next_req.is_alloc;
    exp_rsp.ok       = pattern_mem[idx * pattern_words + 3][0];
    exp_rsp.data     = pattern_mem[idx * pattern_words + 4];

    @(posedge clk);
    req_valid <= 1'b1;
    req       <= next_req;
    do @(negedge clk); while (!req_ready);
    @(posedge clk);
    req_valid <= 1'b0;
    @(negedge clk);
    check_ready(req_ready, 1'b0, "req_ready while busy");

    do @(negedge clk); while (!rsp_valid);
    check_rsp(rsp, exp_rsp, "response");

    // back-pressure, a request offered meanwhile must not be taken
    rng_state = xorshift32(rng_state);
    hold      = rng_state[1:0];
    if (hold != 0) begin
      @(posedge clk);
      req_valid <= 1'b1;
    end
    repeat (hold) begin
      @(negedge clk);
      check_rsp(rsp, exp_rsp, "response held");
      check_ready(rsp_valid, 1'b1, "rsp_valid held");
      check_ready(req_ready, 1'b0, "req_ready under back-pressure");
    end
    @(posedge clk);
    req_valid <= 1'b0;
    rsp_ready <= 1'b1;
    @(posedge clk);
    rsp_ready <= 1'b0;

    if (err_count != errs_before) begin
      failed_tests++;
    end
    $display("test %0d: %s %h, hold %0d, %s", idx, next_req.is_alloc ? "alloc" : "free",
             value, hold, (err_count == errs_before) ? "ok" : "mismatch");
  endtask

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    req_valid    = 1'b0;
    req          = '0;
    rsp_ready    = 1'b0;
    rng_state    = 32'd63;
    cycle_count  = 0;
    err_count    = 0;
    failed_tests = 0;
    $readmemh("test/heap_patterns.txt", pattern_mem);

    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_ready(req_ready, 1'b1, "req_ready after reset");
    check_ready(rsp_valid, 1'b0, "rsp_valid after reset");

    for (int i = 0; i < num_patterns; i++) begin
      run_pattern(i);
    end

    $display("%0d tests, %0d with mismatches, %0d check errors, %0d assertion failures",
             num_patterns, failed_tests, err_count, i_dut.i_assertions.fail_count);
    if ((err_count == 0) && (i_dut.i_assertions.fail_count == 0)) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: test/heap_patterns.txt
// op (1 alloc, 0 free), strategy (0 first fit, 1 best fit), size or payload address,
// expected ok, expected data; all hex
1 0 0020 1 0010
1 0 0010 1 0038
1 0 0040 1 0050
1 0 03e8 0 0000
1 0 0018 1 0098
0 0 0038 1 0000
1 0 0010 1 0038
0 0 0050 1 0000
0 0 0098 1 0000
1 1 0010 1 0098
1 0 0010 1 0050
1 0 0030 1 00b8
1 1 0130 0 0000
1 1 0020 1 0068
1 0 0108 1 00f0
1 0 0008 0 0000
0 0 0010 1 0000
1 1 0020 1 0010

// File: project.f
+incdir+include
verilog/heap_pkg.sv
verilog/heap_header_mem.sv
verilog/heap_list_walker.sv
verilog/heap_list_update.sv
verilog/heap_alloc_ctrl.sv
verilog/heap_alloc_top.sv
test/heap_alloc_assertions.sv
test/heap_alloc_tb.sv

// File: Bender.yml
package:
  name: heap_alloc

export_include_dirs:
  - include

sources:
  - files:
      - verilog/heap_pkg.sv
      - verilog/heap_header_mem.sv
      - verilog/heap_list_walker.sv
      - verilog/heap_list_update.sv
      - verilog/heap_alloc_ctrl.sv
      - verilog/heap_alloc_top.sv
  - target: test
    files:
      - test/heap_alloc_assertions.sv
      - test/heap_alloc_tb.sv
